// ==== soc_pkg.sv ====
// Shared bus widths, operation codes, device map and reset constants, imported by every design block.
`default_nettype none

package soc_pkg;

	// Data word and address widths of the peripheral bus.
	localparam int ARCHBITSZ = 32;
	localparam int ADDRBITSZ = 30;
	localparam int SELBITSZ  = ARCHBITSZ / 8;

	// Bus operation codes.
	localparam logic [1:0] PI1_OP_NOP = 2'd0;
	localparam logic [1:0] PI1_OP_WR  = 2'd1;
	localparam logic [1:0] PI1_OP_RD  = 2'd2;

	// Each device owns a fixed 4 KB window, which is 1024 words.
	localparam int DEVOFFBITSZ = 10;
	localparam int DEVIDXBITSZ = ADDRBITSZ - DEVOFFBITSZ;

	// A bus address read either flat or as device index and word offset.
	typedef union packed {
		logic [ADDRBITSZ-1:0] word;
		struct packed {
			logic [DEVIDXBITSZ-1:0] dev_idx;
			logic [DEVOFFBITSZ-1:0] dev_off;
		} dev;
	} pi1_addr_u;

	// Device indices.
	// Anything above the GPIO index lands on the invalid device.
	localparam logic [1:0] S_DEVTBL  = 2'd0;
	localparam logic [1:0] S_GPIO    = 2'd1;
	localparam logic [1:0] S_INVALID = 2'd2;

	// Device table contents, one entry per index above.
	localparam int DEVCOUNT = 3;
	localparam logic [15:0] DEVTBL_ID [DEVCOUNT] = '{16'd7, 16'd6, 16'd0};
	localparam logic [DEVCOUNT-1:0] DEVTBL_USEINTR = 3'b010;

	// Last word of the table window holds the software reset control.
	localparam logic [DEVOFFBITSZ-1:0] DEVTBL_RSTOFF = 10'd1023;

	// General purpose I/O.
	localparam int GP0IOCOUNT = 16;
	localparam logic [DEVOFFBITSZ-1:0] GPIO_INOFF  = 10'd0;
	localparam logic [DEVOFFBITSZ-1:0] GPIO_OUTOFF = 10'd1;

	// Reset counter width; a full load gives 255 cycles of reset.
	localparam int RST_CNTR_BITSZ = 8;

endpackage

`default_nettype wire

// ==== pi1_if.sv ====
// One peripheral bus link; instantiate per link and connect the master and slave modports.
`timescale 1ns/1ps
`default_nettype none

interface pi1_if import soc_pkg::*; ();

	// Request side, driven by the master.
	logic [1:0]           op;
	pi1_addr_u            addr;
	logic [ARCHBITSZ-1:0] wdata;
	logic [SELBITSZ-1:0]  sel;

	// Response side, driven by the slave.
	logic [ARCHBITSZ-1:0] rdata;
	logic                 rdy;

	modport master (
		 output op
		,output addr
		,output wdata
		,output sel
		,input  rdata
		,input  rdy
	);

	modport slave (
		 input  op
		,input  addr
		,input  wdata
		,input  sel
		,output rdata
		,output rdy
	);

endinterface

`default_nettype wire

// ==== pi1_router.sv ====
// Peripheral bus decoder; steers host requests by device window and returns the selected read data.
`timescale 1ns/1ps
`default_nettype none

module pi1_router import soc_pkg::*; (
	 input  logic  clk100mhz_i
	,input  logic  sys_rst_i
	,pi1_if.slave  host
	,pi1_if.master devtbl_m
	,pi1_if.master gpio_m
);

	logic [1:0] req_dev;
	logic [1:0] rd_dev_q;
	logic       dev_rdy;
	logic       accept;

	// Window decode on the device index.
	always_comb begin
		if (host.addr.dev.dev_idx == DEVIDXBITSZ'(S_DEVTBL)) begin
			req_dev = S_DEVTBL;
		end else if (host.addr.dev.dev_idx == DEVIDXBITSZ'(S_GPIO)) begin
			req_dev = S_GPIO;
		end else begin
			req_dev = S_INVALID;
		end
	end

	// Only the selected device sees the request, the others see NOP.
	assign devtbl_m.op = (req_dev == S_DEVTBL) ? host.op : PI1_OP_NOP;
	assign gpio_m.op   = (req_dev == S_GPIO) ? host.op : PI1_OP_NOP;

	// Devices get the offset only.
	assign devtbl_m.addr.word = {{DEVIDXBITSZ{1'b0}}, host.addr.dev.dev_off};
	assign gpio_m.addr.word   = {{DEVIDXBITSZ{1'b0}}, host.addr.dev.dev_off};

	assign devtbl_m.wdata = host.wdata;
	assign gpio_m.wdata   = host.wdata;
	assign devtbl_m.sel   = host.sel;
	assign gpio_m.sel     = host.sel;

	// The invalid device is always ready and drops writes.
	always_comb begin
		case (req_dev)
			S_DEVTBL: dev_rdy = devtbl_m.rdy;
			S_GPIO:   dev_rdy = gpio_m.rdy;
			default:  dev_rdy = 1'b1;
		endcase
	end

	// Requests wait while the system is in reset.
	assign host.rdy = dev_rdy && !sys_rst_i;

	assign accept = host.rdy && (host.op != PI1_OP_NOP);

	// Remember which device took the request, its data shows up next cycle.
	always_ff @(posedge clk100mhz_i) begin
		if (sys_rst_i) begin
			rd_dev_q <= S_INVALID;
		end else if (accept) begin
			rd_dev_q <= req_dev;
		end
	end

	always_comb begin
		case (rd_dev_q)
			S_DEVTBL: host.rdata = devtbl_m.rdata;
			S_GPIO:   host.rdata = gpio_m.rdata;
			default:  host.rdata = '0;
		endcase
	end

endmodule

`default_nettype wire

// ==== reset_seq.sv ====
// System reset sequencer; combines the board reset with software warm reset and power-off requests.
`timescale 1ns/1ps
`default_nettype none

module reset_seq import soc_pkg::*; (
	 input  logic clk100mhz_i
	,input  logic rst_p
	,input  logic rst0_i
	,input  logic rst1_i
	,output logic sys_rst_o
);

	logic [RST_CNTR_BITSZ-1:0] rst_cntr;
	logic                      pwroff_q;
	logic                      swrst;
	logic                      swpwroff;

	// rst1 alone is a warm reset.
	// With rst0 also set it was a cold reset, which is handled the same way here.
	assign swrst    = rst1_i;
	assign swpwroff = rst0_i && !rst1_i;

	// Reload counter, held full while any reset source is active.
	always_ff @(posedge clk100mhz_i) begin
		if (rst_p || swrst) begin
			rst_cntr <= '1;
		end else if (rst_cntr != '0) begin
			rst_cntr <= rst_cntr - 1'b1;
		end
	end

	// Power-off latch.
	// Only the board reset brings the system back.
	always_ff @(posedge clk100mhz_i) begin
		if (rst_p) begin
			pwroff_q <= 1'b0;
		end else if (swpwroff) begin
			pwroff_q <= 1'b1;
		end
	end

	assign sys_rst_o = pwroff_q || (rst_cntr != '0);

endmodule

`default_nettype wire

// ==== devtbl.sv ====
// Device table slave; returns the fixed device list and holds the software reset control word.
`timescale 1ns/1ps
`default_nettype none

module devtbl import soc_pkg::*; (
	 input  logic clk100mhz_i
	,input  logic sys_rst_i
	,pi1_if.slave bus
	,output logic rst0_o
	,output logic rst1_o
);

	logic [DEVOFFBITSZ-1:0] off;
	logic [ARCHBITSZ-1:0]   rd_word;
	logic                   accept;
	logic                   ctrl_wr;

	// Single-cycle slave, never stalls.
	assign bus.rdy = 1'b1;

	assign off    = bus.addr.dev.dev_off;
	assign accept = bus.rdy && (bus.op != PI1_OP_NOP);

	// Control word takes byte lane 0 only.
	assign ctrl_wr = accept && (bus.op == PI1_OP_WR) && (off == DEVTBL_RSTOFF) && bus.sel[0];

	// Table entry layout.
	// Bits 15..0 hold the id, bit 16 the interrupt flag.
	always_comb begin
		rd_word = '0;
		if (off == DEVTBL_RSTOFF) begin
			rd_word[1:0] = {rst1_o, rst0_o};
		end else begin
			for (int k = 0; k < DEVCOUNT; k++) begin
				if (off == k) begin
					rd_word[15:0] = DEVTBL_ID[k];
					rd_word[16]   = DEVTBL_USEINTR[k];
				end
			end
		end
	end

	// Read data follows one cycle after acceptance.
	always_ff @(posedge clk100mhz_i) begin
		if (accept && (bus.op == PI1_OP_RD)) begin
			bus.rdata <= rd_word;
		end
	end

	// System reset ends whatever software request set these bits.
	always_ff @(posedge clk100mhz_i) begin
		if (sys_rst_i) begin
			rst0_o <= 1'b0;
			rst1_o <= 1'b0;
		end else if (ctrl_wr) begin
			rst0_o <= bus.wdata[0];
			rst1_o <= bus.wdata[1];
		end
	end

endmodule

`default_nettype wire

// ==== gpio.sv ====
// General purpose I/O slave; synchronized input port at offset 0 and output register at offset 1.
`timescale 1ns/1ps
`default_nettype none

module gpio import soc_pkg::*; (
	 input  logic                  clk100mhz_i
	,input  logic                  sys_rst_i
	,pi1_if.slave                  bus
	,input  logic [GP0IOCOUNT-1:0] gp0_i
	,output logic [GP0IOCOUNT-1:0] gp0_o
);

	logic [GP0IOCOUNT-1:0]  in_meta_q;
	logic [GP0IOCOUNT-1:0]  in_sync_q;
	logic [GP0IOCOUNT-1:0]  out_q;
	logic [DEVOFFBITSZ-1:0] off;
	logic [ARCHBITSZ-1:0]   rd_word;
	logic                   accept;
	logic                   out_wr;

	assign bus.rdy = 1'b1;

	assign off    = bus.addr.dev.dev_off;
	assign accept = bus.rdy && (bus.op != PI1_OP_NOP);
	assign out_wr = accept && (bus.op == PI1_OP_WR) && (off == GPIO_OUTOFF);

	// Two-stage synchronizer for the asynchronous pins.
	always_ff @(posedge clk100mhz_i) begin
		in_meta_q <= gp0_i;
		in_sync_q <= in_meta_q;
	end

	// Output register, written per byte lane.
	always_ff @(posedge clk100mhz_i) begin
		if (sys_rst_i) begin
			out_q <= '0;
		end else if (out_wr) begin
			for (int b = 0; b < GP0IOCOUNT / 8; b++) begin
				if (bus.sel[b]) begin
					out_q[b*8 +: 8] <= bus.wdata[b*8 +: 8];
				end
			end
		end
	end

	assign gp0_o = out_q;

	always_comb begin
		rd_word = '0;
		if (off == GPIO_INOFF) begin
			rd_word[GP0IOCOUNT-1:0] = in_sync_q;
		end else if (off == GPIO_OUTOFF) begin
			rd_word[GP0IOCOUNT-1:0] = out_q;
		end
	end

	// Registered read data, valid the cycle after acceptance.
	always_ff @(posedge clk100mhz_i) begin
		if (accept && (bus.op == PI1_OP_RD)) begin
			bus.rdata <= rd_word;
		end
	end

endmodule

`default_nettype wire

// ==== nexys_soc.sv ====
// Top level of the board control SoC; the external bus master drives the plain pi1 ports.
`timescale 1ns/1ps
`default_nettype none

module nexys_soc import soc_pkg::*; (
	 input  logic                  clk100mhz_i
	,input  logic                  rst_p
	,input  logic [1:0]            pi1_op_i
	,input  logic [ADDRBITSZ-1:0]  pi1_addr_i
	,input  logic [ARCHBITSZ-1:0]  pi1_data_i
	,input  logic [SELBITSZ-1:0]   pi1_sel_i
	,input  logic [GP0IOCOUNT-1:0] gp0_i
	,output logic [ARCHBITSZ-1:0]  pi1_data_o
	,output logic                  pi1_rdy_o
	,output logic [GP0IOCOUNT-1:0] gp0_o
	,output logic                  sys_rst_o
);

	logic sys_rst;
	logic devtbl_rst0;
	logic devtbl_rst1;

	pi1_if host_bus ();
	pi1_if devtbl_bus ();
	pi1_if gpio_bus ();

	// External master onto the host link.
	assign host_bus.op        = pi1_op_i;
	assign host_bus.addr.word = pi1_addr_i;
	assign host_bus.wdata     = pi1_data_i;
	assign host_bus.sel       = pi1_sel_i;
	assign pi1_data_o         = host_bus.rdata;
	assign pi1_rdy_o          = host_bus.rdy;

	assign sys_rst_o = sys_rst;

	reset_seq reset_seq (
		 .clk100mhz_i (clk100mhz_i)
		,.rst_p       (rst_p)
		,.rst0_i      (devtbl_rst0)
		,.rst1_i      (devtbl_rst1)
		,.sys_rst_o   (sys_rst)
	);

	pi1_router pi1_router (
		 .clk100mhz_i (clk100mhz_i)
		,.sys_rst_i   (sys_rst)
		,.host        (host_bus.slave)
		,.devtbl_m    (devtbl_bus.master)
		,.gpio_m      (gpio_bus.master)
	);

	devtbl devtbl (
		 .clk100mhz_i (clk100mhz_i)
		,.sys_rst_i   (sys_rst)
		,.bus         (devtbl_bus.slave)
		,.rst0_o      (devtbl_rst0)
		,.rst1_o      (devtbl_rst1)
	);

	// Switches in, LEDs out.
	gpio gpio_switches_leds (
		 .clk100mhz_i (clk100mhz_i)
		,.sys_rst_i   (sys_rst)
		,.bus         (gpio_bus.slave)
		,.gp0_i       (gp0_i)
		,.gp0_o       (gp0_o)
	);

endmodule

`default_nettype wire

// ==== nexys_soc_asserts.sv ====
// Concurrent checks on reset sequencing and host ready; bound onto the SoC top level.
`timescale 1ns/1ps
`default_nettype none

module nexys_soc_asserts (
	 input logic        clk100mhz_i
	,input logic        rst_p
	,input logic        sys_rst_o
	,input logic        pi1_rdy_o
	,input logic [15:0] gp0_o
);

	// Host requests must wait while the system is in reset.
	rdy_low_in_reset: assert property (@(posedge clk100mhz_i) sys_rst_o |-> !pi1_rdy_o)
		else $error("pi1_rdy_o was high while sys_rst_o was high");

	board_reset_raises_sys_rst: assert property (@(posedge clk100mhz_i) rst_p |=> sys_rst_o)
		else $error("sys_rst_o stayed low one cycle after rst_p");

	// LED register clears at the first reset edge.
	reset_clears_leds: assert property (@(posedge clk100mhz_i) sys_rst_o |=> (gp0_o == 16'h0))
		else $error("gp0_o was not cleared one cycle after sys_rst_o");

endmodule

bind nexys_soc nexys_soc_asserts reset_bus_checks (
	 .clk100mhz_i (clk100mhz_i)
	,.rst_p       (rst_p)
	,.sys_rst_o   (sys_rst_o)
	,.pi1_rdy_o   (pi1_rdy_o)
	,.gp0_o       (gp0_o)
);

`default_nettype wire

// ==== tb_nexys_soc.sv ====
// Testbench for the board control SoC; drives the host bus ports and checks against a behavioral model.
`timescale 1ns/1ps
`default_nettype none

module tb_nexys_soc;

	// Word addresses are the device index times 1024 plus the word offset.
	localparam logic [29:0] RST_CTRL_ADDR = 30'h3FF;
	localparam logic [29:0] GPIO_IN_ADDR  = 30'h400;
	localparam logic [29:0] GPIO_OUT_ADDR = 30'h401;
	localparam int          BUS_TIMEOUT   = 20;

	logic        clk100mhz_i;
	logic        rst_p;
	logic [1:0]  pi1_op_i;
	logic [29:0] pi1_addr_i;
	logic [31:0] pi1_data_i;
	logic [3:0]  pi1_sel_i;
	logic [15:0] gp0_i;
	logic [31:0] pi1_data_o;
	logic        pi1_rdy_o;
	logic [15:0] gp0_o;
	logic        sys_rst_o;

	// Reference state for the LED register and the table words.
	logic [15:0] gpio_model;
	logic [31:0] table_model [4];
	int          checks;
	int          errors;
	int          tests_run;
	int          tests_failed;
	int          err_mark;
	bit          timed_out;

	nexys_soc DUT (.*);

	always #5 clk100mhz_i = ~clk100mhz_i;

	task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
		checks++;
		assert (exp === act) else begin
			$display("mismatch %s: expected %h, actual %h", name, exp, act);
			errors++;
		end
	endtask

	task automatic report_timeout(input string what);
		$display("timeout: %s did not happen in time", what);
		errors++;
		timed_out = 1'b1;
	endtask

	// Polls on falling edges, where registered outputs have settled.
	task automatic wait_sys_rst(input logic level, input int limit, input string what);
		int n;
		n = 0;
		while (sys_rst_o !== level && n < limit) begin
			@(negedge clk100mhz_i);
			n++;
		end
		if (sys_rst_o !== level) report_timeout(what);
	endtask

	task automatic bus_request(input logic [1:0] op, input logic [29:0] addr,
			input logic [31:0] data, input logic [3:0] sel);
		int n;
		if (timed_out) return;
		@(posedge clk100mhz_i);
		#1;
		pi1_op_i   = op;
		pi1_addr_i = addr;
		pi1_data_i = data;
		pi1_sel_i  = sel;
		n = 0;
		@(negedge clk100mhz_i);
		while (!pi1_rdy_o && n < BUS_TIMEOUT) begin
			@(negedge clk100mhz_i);
			n++;
		end
		if (!pi1_rdy_o) report_timeout("bus ready");
		// Accepted at the coming rising edge.
		@(posedge clk100mhz_i);
		#1;
		pi1_op_i = 2'd0;
	endtask

	task automatic bus_write(input logic [29:0] addr, input logic [31:0] data, input logic [3:0] sel);
		bus_request(2'd1, addr, data, sel);
	endtask

	// Data is registered at the accepting edge and sampled half a cycle later.
	task automatic bus_read(input logic [29:0] addr, output logic [31:0] data);
		bus_request(2'd2, addr, 32'h0, 4'hF);
		@(negedge clk100mhz_i);
		data = pi1_data_o;
	endtask

	task automatic end_test(input string name);
		tests_run++;
		if (errors == err_mark) begin
			$display("test %s: ok", name);
		end else begin
			tests_failed++;
			$display("test %s: failed, %0d errors", name, errors - err_mark);
		end
		err_mark = errors;
	endtask

	// Byte-lane write into the 16-bit output register.
	function automatic logic [15:0] merge_lanes(input logic [15:0] old, input logic [15:0] data,
			input logic [1:0] sel);
		logic [15:0] res;
		res = old;
		if (sel[0]) res[7:0] = data[7:0];
		if (sel[1]) res[15:8] = data[15:8];
		return res;
	endfunction

	initial begin
		logic [31:0] rnd;
		logic [31:0] rdata;
		logic [31:0] wdata;
		logic [19:0] idx;
		int          lows;
		rnd = $urandom(701);
		clk100mhz_i = 1'b0;
		rst_p       = 1'b1;
		pi1_op_i    = 2'd0;
		pi1_addr_i  = '0;
		pi1_data_i  = '0;
		pi1_sel_i   = '0;
		gp0_i       = '0;
		gpio_model  = '0;
		// Entry word is the id in bits 15..0 and the interrupt flag in bit 16.
		table_model[0] = 32'h0000_0007;
		table_model[1] = 32'h0001_0006;
		table_model[2] = 32'h0;
		table_model[3] = 32'h0;

		repeat (3) @(posedge clk100mhz_i);
		#1;
		rst_p = 1'b0;
		wait_sys_rst(1'b0, 300, "release of sys_rst after reset");
		check("reset_gp0", 32'h0, {16'h0, gp0_o});
		check("reset_rdy", 32'h1, {31'h0, pi1_rdy_o});
		end_test("reset_release");

		for (int k = 0; k < 4; k++) begin
			bus_read({20'd0, 10'(k)}, rdata);
			check("devtbl_entry", table_model[k], rdata);
		end
		end_test("device_table");

		for (int k = 0; k < 200 && !timed_out; k++) begin
			wdata = $urandom;
			rnd   = $urandom;
			bus_write(GPIO_OUT_ADDR, wdata, rnd[3:0]);
			gpio_model = merge_lanes(gpio_model, wdata[15:0], rnd[1:0]);
			check("gpio_pins", {16'h0, gpio_model}, {16'h0, gp0_o});
			if (rnd[4]) begin
				bus_read(GPIO_OUT_ADDR, rdata);
				check("gpio_readback", {16'h0, gpio_model}, rdata);
			end
		end
		end_test("gpio_random_writes");

		for (int k = 0; k < 8; k++) begin
			rnd = $urandom;
			@(posedge clk100mhz_i);
			#1;
			gp0_i = rnd[15:0];
			repeat (3) @(posedge clk100mhz_i);
			bus_read(GPIO_IN_ADDR, rdata);
			check("gpio_input", {16'h0, rnd[15:0]}, rdata);
		end
		end_test("gpio_input");

		for (int k = 0; k < 40; k++) begin
			rnd   = $urandom;
			wdata = $urandom;
			idx   = (rnd[19:0] < 20'd2) ? rnd[19:0] + 20'd2 : rnd[19:0];
			bus_read({idx, wdata[9:0]}, rdata);
			check("invalid_read", 32'h0, rdata);
			check("invalid_rdy", 32'h1, {31'h0, pi1_rdy_o});
			bus_write({idx, wdata[9:0]}, wdata, 4'hF);
		end
		check("invalid_gp0", {16'h0, gpio_model}, {16'h0, gp0_o});
		bus_read(GPIO_OUT_ADDR, rdata);
		check("invalid_gpio_kept", {16'h0, gpio_model}, rdata);
		for (int k = 0; k < 3; k++) begin
			bus_read({20'd0, 10'(k)}, rdata);
			check("invalid_table_kept", table_model[k], rdata);
		end
		bus_read(RST_CTRL_ADDR, rdata);
		check("invalid_ctrl_kept", 32'h0, rdata);
		end_test("invalid_device");

		bus_write(GPIO_OUT_ADDR, 32'h0000_A5C3, 4'h3);
		bus_write(RST_CTRL_ADDR, 32'h2, 4'h1);
		wait_sys_rst(1'b1, 5, "warm reset raising sys_rst");
		wait_sys_rst(1'b0, 300, "end of warm reset");
		gpio_model = '0;
		check("warm_gp0", 32'h0, {16'h0, gp0_o});
		bus_read(GPIO_OUT_ADDR, rdata);
		check("warm_gpio_read", 32'h0, rdata);
		bus_read(RST_CTRL_ADDR, rdata);
		check("warm_ctrl_cleared", 32'h0, rdata);
		end_test("warm_reset");

		// LEDs are lit first so the release check sees them cleared.
		bus_write(GPIO_OUT_ADDR, 32'h0000_3C5A, 4'h3);
		gpio_model = merge_lanes(gpio_model, 16'h3C5A, 2'b11);
		check("poweroff_gp0_set", {16'h0, gpio_model}, {16'h0, gp0_o});
		bus_write(RST_CTRL_ADDR, 32'h1, 4'h1);
		wait_sys_rst(1'b1, 5, "power-off raising sys_rst");
		lows = 0;
		repeat (600) begin
			@(negedge clk100mhz_i);
			if (!sys_rst_o) lows++;
		end
		check("poweroff_low_cycles", 32'h0, 32'(lows));
		@(posedge clk100mhz_i);
		#1;
		rst_p = 1'b1;
		repeat (3) @(posedge clk100mhz_i);
		#1;
		rst_p = 1'b0;
		wait_sys_rst(1'b0, 300, "release of sys_rst after power-off");
		gpio_model = '0;
		check("poweroff_gp0", {16'h0, gpio_model}, {16'h0, gp0_o});
		end_test("power_off");

		$display("tests: %0d run, %0d failed; checks: %0d, errors: %0d",
			tests_run, tests_failed, checks, errors);
		if (errors == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== nexys_soc.f ====
soc_pkg.sv
pi1_if.sv
pi1_router.sv
reset_seq.sv
devtbl.sv
gpio.sv
nexys_soc.sv
nexys_soc_asserts.sv
tb_nexys_soc.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert --top-module tb_nexys_soc -f nexys_soc.f
status=0
./obj_dir/Vtb_nexys_soc > sim.log 2>&1 || status=$?
cat sim.log
if grep -q "Simulation FAILED" sim.log; then
	exit 1
fi
if [ "$status" -ne 0 ] || ! grep -q "Simulation PASSED" sim.log; then
	echo "simulation ended without a pass result"
	exit 1
fi
